// ==== tb.f ====
+incdir+verilog
verilog/mpf_pkg.sv
verilog/mpf_fifo_lutram.sv
verilog/mpf_shim_buffer_afu.sv
verilog/mpf_tx_arbiter.sv
verilog/mpf_fiu_tx_stage.sv
verilog/mpf_shim_top.sv
sim/mpf_shim_properties.sv
sim/tb_mpf_shim.sv

// ==== Makefile ====
# Verilator flow for the MPF request path testbench

VERILATOR ?= verilator
TOP       ?= tb_mpf_shim
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Result: PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_mpf_shim.sv ====
// ====================
// MPF request path testbench
// Random AFU traffic checked against per-channel queues
// ====================

`include "mpf_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module tb_mpf_shim
    import mpf_pkg::*;
();

    localparam int THRESHOLD = `MPF_ALM_FULL_THRESHOLD;
    localparam int DEPTH     = THRESHOLD + 2;
    localparam int N_SOLO    = 20;
    // Enough traffic before the second reset to wrap the 8-bit tag
    localparam int N_RAND    = 240;
    localparam int N_TOTAL   = 2 * N_SOLO + N_RAND + 4 * DEPTH;
    localparam int TIMEOUT   = 40 * N_TOTAL + 500;

    logic         clk = 1'b0;
    logic         arst_n = 1'b0;
    logic         c0_valid = 1'b0;
    t_mpf_c0_req  c0_req = '0;
    logic         c0_alm_full;
    logic         c1_valid = 1'b0;
    t_mpf_c1_req  c1_req = '0;
    logic         c1_alm_full;
    logic         fiu_alm_full = 1'b0;
    logic         fiu_tx_valid;
    t_mpf_fiu_req fiu_tx;

    // Scoreboard state
    t_mpf_c0_req              c0_q[$];
    t_mpf_c1_req              c1_q[$];
    logic [`MPF_TAG_BITS-1:0] exp_tag = '0;
    logic                     af_prev = 1'b0;
    logic                     check_alt = 1'b0;
    t_mpf_chan                alt_next = CHAN_C0;
    int                       slack0 = 0;
    int                       slack1 = 0;
    int                       cycle_count = 0;
    logic [31:0]              rnd_state = 32'd97;

    always #4 clk = ~clk;

    mpf_shim_top dut_i
    (
        .clk, .arst_n,
        .c0_valid, .c0_req, .c0_alm_full,
        .c1_valid, .c1_req, .c1_alm_full,
        .fiu_alm_full, .fiu_tx_valid, .fiu_tx
    );

    // Buffer checks follow the FIFO strobes rather than the raw AFU strobes
    bind mpf_shim_buffer_afu mpf_shim_properties #(.CHECK_FIFO(1'b1)) buf_props_i
    (
        .clk(clk), .arst_n(arst_n),
        .c0_enq(c0_fifo_enq), .c0_deq(c0_fifo_deq),
        .c1_enq(c1_valid), .c1_deq(c1_deq),
        .fiu_alm_full(1'b0), .grant_valid(1'b0)
    );

    bind mpf_tx_arbiter mpf_shim_properties #(.CHECK_FIFO(1'b0)) arb_props_i
    (
        .clk(clk), .arst_n(arst_n),
        .c0_enq(1'b0), .c0_deq(c0_deq),
        .c1_enq(1'b0), .c1_deq(c1_deq),
        .fiu_alm_full(fiu_alm_full), .grant_valid(grant_valid)
    );

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    // Reads carry no data and writes keep theirs. The tag counts issued requests
    function automatic t_mpf_fiu_req expected_req(input t_mpf_chan chan,
                                                  input t_mpf_c1_req src,
                                                  input logic [`MPF_TAG_BITS-1:0] tag);
        t_mpf_fiu_req r;
        r.op   = (chan == CHAN_C1) ? REQ_WR : REQ_RD;
        r.addr = src.addr;
        r.data = (chan == CHAN_C1) ? src.data : '0;
        r.tag  = tag;
        return r;
    endfunction

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        if (got !== want)
        begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
            stop_run();
        end
    endtask

    // One cycle of AFU traffic. The AFU keeps sending after alm_full rises
    // only while it has slack left
    task automatic drive_cycle(input logic want0, input logic want1, input logic af,
                               output int sent);
        t_mpf_c0_req r0;
        t_mpf_c1_req r1;
        logic        go0;
        logic        go1;
        if (!c0_alm_full)
            slack0 = 0;
        if (!c1_alm_full)
            slack1 = 0;
        go0 = want0 && (!c0_alm_full || slack0 < THRESHOLD);
        go1 = want1 && (!c1_alm_full || slack1 < THRESHOLD);
        if (go0 && c0_alm_full)
            slack0++;
        if (go1 && c1_alm_full)
            slack1++;
        r0.addr = rand32();
        r1.addr = rand32();
        r1.data = {rand32(), rand32()};
        c0_valid     = go0;
        c0_req       = r0;
        c1_valid     = go1;
        c1_req       = r1;
        fiu_alm_full = af;
        if (go0)
            c0_q.push_back(r0);
        if (go1)
            c1_q.push_back(r1);
        sent = int'(go0) + int'(go1);
        @(posedge clk);
        #1;
    endtask

    // Release the FIU and idle until every queued request has come out
    task automatic drain();
        int n;
        while (c0_q.size() != 0 || c1_q.size() != 0)
            drive_cycle(1'b0, 1'b0, 1'b0, n);
        repeat (4)
            drive_cycle(1'b0, 1'b0, 1'b0, n);
    endtask

    task automatic apply_reset();
        arst_n       = 1'b0;
        c0_valid     = 1'b0;
        c1_valid     = 1'b0;
        fiu_alm_full = 1'b0;
        slack0       = 0;
        slack1       = 0;
        c0_q.delete();
        c1_q.delete();
        repeat (5)
            @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_value("fiu_tx_valid", fiu_tx_valid, 1'b0);
        check_value("c0_alm_full", c0_alm_full, 1'b0);
        check_value("c1_alm_full", c1_alm_full, 1'b0);
    endtask

    // ====================
    // Comparison
    // ====================

    task automatic compare_output();
        t_mpf_chan    chan;
        t_mpf_c0_req  rd;
        t_mpf_c1_req  src;
        t_mpf_fiu_req want;
        chan = (fiu_tx.op == REQ_WR) ? CHAN_C1 : CHAN_C0;
        if (check_alt)
        begin
            check_value("fiu_tx.op", fiu_tx.op, (alt_next == CHAN_C1) ? REQ_WR : REQ_RD);
            alt_next = (alt_next == CHAN_C0) ? CHAN_C1 : CHAN_C0;
        end
        if ((chan == CHAN_C0 && c0_q.size() == 0) || (chan == CHAN_C1 && c1_q.size() == 0))
        begin
            $display("FIU request issued with no matching AFU request");
            stop_run();
        end
        if (chan == CHAN_C0)
        begin
            rd       = c0_q.pop_front();
            src.addr = rd.addr;
            src.data = '0;
        end
        else
            src = c1_q.pop_front();
        want = expected_req(chan, src, exp_tag);
        check_value("fiu_tx.addr", fiu_tx.addr, want.addr);
        check_value("fiu_tx.data", fiu_tx.data, want.data);
        check_value("fiu_tx.tag", fiu_tx.tag, want.tag);
        exp_tag = exp_tag + 1'b1;
    endtask

    // Outputs are sampled at the falling edge where they have settled
    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            exp_tag = '0;
            af_prev = 1'b0;
        end
        else
        begin
            // A stalled cycle grants nothing, so the next one issues nothing
            if (af_prev)
                check_value("fiu_tx_valid", fiu_tx_valid, 1'b0);
            if (fiu_tx_valid)
                compare_output();
            af_prev = fiu_alm_full;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT)
        begin
            $display("Timeout after %0d cycles, requests still pending", cycle_count);
            stop_run();
        end
    end

    // ====================
    // Stimulus
    // ====================

    initial
    begin
        int          n;
        int          sent;
        logic [31:0] r;
        apply_reset();

        // Reads alone, then writes alone
        sent = 0;
        while (sent < N_SOLO)
        begin
            drive_cycle(1'b1, 1'b0, 1'b0, n);
            sent += n;
        end
        drain();
        sent = 0;
        while (sent < N_SOLO)
        begin
            drive_cycle(1'b0, 1'b1, 1'b0, n);
            sent += n;
        end
        drain();

        // Mixed traffic with the FIU stalled about a quarter of the time
        sent = 0;
        while (sent < N_RAND)
        begin
            r = rand32();
            drive_cycle(r[0], r[1], r[3:2] == 2'b00, n);
            sent += n;
        end
        drain();

        // Fill one channel against a stalled FIU, using all of the slack
        for (int ch = 0; ch < 2; ch++)
        begin
            for (int k = 1; k <= DEPTH; k++)
            begin
                drive_cycle(ch == 0, ch == 1, 1'b1, n);
                check_value("requests sent", n, 1);
                check_value(ch == 0 ? "c0_alm_full" : "c1_alm_full",
                            ch == 0 ? c0_alm_full : c1_alm_full, (DEPTH - k) <= THRESHOLD);
            end
            drain();
        end

        // Both FIFOs full after reset drain in strict alternation from channel 0
        apply_reset();
        check_alt = 1'b1;
        alt_next  = CHAN_C0;
        for (int k = 0; k < DEPTH; k++)
            drive_cycle(1'b1, 1'b1, 1'b1, n);
        drain();
        check_alt = 1'b0;

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/mpf_shim_properties.sv ====
// ====================
// MPF shim assertions
// FIFO overflow, single grant and FIU almost-full checks
// ====================

`include "mpf_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module mpf_shim_properties
#(
    // One instance watches the buffer FIFOs and the other watches the arbiter
    parameter bit CHECK_FIFO = 1'b0
)
(
    input  logic clk,
    input  logic arst_n,
    input  logic c0_enq,
    input  logic c0_deq,
    input  logic c1_enq,
    input  logic c1_deq,
    input  logic fiu_alm_full,
    input  logic grant_valid
);

    localparam int unsigned DEPTH = `MPF_ALM_FULL_THRESHOLD + 2;

    generate
        if (CHECK_FIFO)
        begin : g_fifo
            // Shadow occupancy rebuilt from the enqueue and dequeue strobes
            int unsigned occ0;
            int unsigned occ1;

            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    occ0 <= 0;
                    occ1 <= 0;
                end
                else
                begin
                    occ0 <= occ0 + (c0_enq ? 1 : 0) - (c0_deq ? 1 : 0);
                    occ1 <= occ1 + (c1_enq ? 1 : 0) - (c1_deq ? 1 : 0);
                end
            end

            a_c0_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
                (c0_enq && !c0_deq) |-> (occ0 < DEPTH))
                else $error("Channel 0 FIFO written while full");
            a_c1_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
                (c1_enq && !c1_deq) |-> (occ1 < DEPTH))
                else $error("Channel 1 FIFO written while full");
            a_c0_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
                c0_deq |-> (occ0 != 0))
                else $error("Channel 0 FIFO read while empty");
            a_c1_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
                c1_deq |-> (occ1 != 0))
                else $error("Channel 1 FIFO read while empty");
        end
        else
        begin : g_grant
            a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
                !(c0_deq && c1_deq))
                else $error("Both channels dequeued in one cycle");
            // The FIU must see nothing granted while it is near full
            a_fiu_stall: assert property (@(posedge clk) disable iff (!arst_n)
                fiu_alm_full |-> !grant_valid)
                else $error("Grant issued while the FIU was almost full");
        end
    endgenerate

endmodule

`default_nettype wire

// ==== verilog/mpf_shim_top.sv ====
// ====================
// MPF request path top
// Buffer, arbiter and output stage between the AFU and the FIU
// ====================

`include "mpf_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module mpf_shim_top
    import mpf_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,

    // AFU request channels
    input  logic         c0_valid,
    input  t_mpf_c0_req  c0_req,
    output logic         c0_alm_full,
    input  logic         c1_valid,
    input  t_mpf_c1_req  c1_req,
    output logic         c1_alm_full,

    // FIU request channel
    input  logic         fiu_alm_full,
    output logic         fiu_tx_valid,
    output t_mpf_fiu_req fiu_tx
);

    // Buffered heads and their dequeues
    logic         c0_head_valid;
    t_mpf_c0_req  c0_head;
    logic         c1_head_valid;
    t_mpf_c1_req  c1_head;
    logic         c0_deq;
    logic         c1_deq;

    // Winning request before the output register
    logic         grant_valid;
    t_mpf_fiu_req grant_req;

    mpf_shim_buffer_afu #(.ENABLE_C0_BYPASS(`MPF_C0_BYPASS)) buf_i
    (
        .clk, .arst_n,
        .c0_valid, .c0_req, .c0_alm_full,
        .c1_valid, .c1_req, .c1_alm_full,
        .c0_head_valid, .c0_head, .c1_head_valid, .c1_head,
        .c0_deq, .c1_deq
    );

    mpf_tx_arbiter arb_i
    (
        .clk, .arst_n,
        .c0_head_valid, .c0_head, .c1_head_valid, .c1_head,
        .c0_deq, .c1_deq,
        .fiu_alm_full,
        .grant_valid, .grant_req
    );

    mpf_fiu_tx_stage tx_i
    (
        .clk, .arst_n,
        .grant_valid, .grant_req,
        .fiu_tx_valid, .fiu_tx
    );

endmodule

`default_nettype wire

// ==== verilog/mpf_fiu_tx_stage.sv ====
// ====================
// FIU output stage
// Registers the granted request and stamps the running tag
// ====================

`include "mpf_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module mpf_fiu_tx_stage
    import mpf_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,

    input  logic         grant_valid,
    input  t_mpf_fiu_req grant_req,

    // One-cycle strobe, the FIU applies no back-pressure
    output logic         fiu_tx_valid,
    output t_mpf_fiu_req fiu_tx
);

    // Counts issued requests and wraps naturally at the tag width.
    // Responses are matched against this value later
    logic [`MPF_TAG_BITS-1:0] tag_cnt;

    // ====================
    // Control
    // ====================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fiu_tx_valid <= 1'b0;
            tag_cnt      <= '0;
        end
        else
        begin
            fiu_tx_valid <= grant_valid;
            if (grant_valid)
                tag_cnt <= tag_cnt + 1'b1;
        end
    end

    // Payload only loads on a grant and is qualified by fiu_tx_valid
    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            fiu_tx     <= grant_req;
            fiu_tx.tag <= tag_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mpf_tx_arbiter.sv ====
// ====================
// Request arbiter
// Round-robin pick between the two buffered heads toward the FIU
// ====================

`timescale 1ns/1ps
`default_nettype none

module mpf_tx_arbiter
    import mpf_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,

    input  logic         c0_head_valid,
    input  t_mpf_c0_req  c0_head,
    input  logic         c1_head_valid,
    input  t_mpf_c1_req  c1_head,

    // Dequeues answer the heads in the same cycle
    output logic         c0_deq,
    output logic         c1_deq,

    input  logic         fiu_alm_full,

    output logic         grant_valid,
    output t_mpf_fiu_req grant_req
);

    // Channel that won the most recent grant
    t_mpf_chan last_grant;

    logic pick_c0;
    logic pick_c1;

    // ====================
    // Grant selection
    // ====================

    always_comb
    begin
        pick_c0 = 1'b0;
        pick_c1 = 1'b0;

        // Nothing leaves while the FIU is near full
        if (!fiu_alm_full)
        begin
            if (c0_head_valid && c1_head_valid)
            begin
                // Both waiting, so the channel that lost last time wins
                pick_c1 = (last_grant == CHAN_C0);
                pick_c0 = (last_grant == CHAN_C1);
            end
            else
            begin
                pick_c0 = c0_head_valid;
                pick_c1 = c1_head_valid;
            end
        end
    end

    // Reset state points at channel 1 so channel 0 wins the first contest
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            last_grant <= CHAN_C1;
        else if (pick_c0)
            last_grant <= CHAN_C0;
        else if (pick_c1)
            last_grant <= CHAN_C1;
    end

    assign c0_deq      = pick_c0;
    assign c1_deq      = pick_c1;
    assign grant_valid = pick_c0 || pick_c1;

    // ====================
    // Request formation
    // ====================

    // The tag stays zero here and is filled in by the output stage
    always_comb
    begin
        grant_req = '0;
        if (pick_c1)
        begin
            grant_req.op   = REQ_WR;
            grant_req.addr = c1_head.addr;
            grant_req.data = c1_head.data;
        end
        else
        begin
            grant_req.op   = REQ_RD;
            grant_req.addr = c0_head.addr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mpf_shim_buffer_afu.sv ====
// ====================
// AFU-side request buffer
// One FIFO per channel with explicit dequeue and an optional C0 bypass
// ====================

`include "mpf_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module mpf_shim_buffer_afu
    import mpf_pkg::*;
#(
    parameter int ENABLE_C0_BYPASS = `MPF_C0_BYPASS
)
(
    input  logic        clk,
    input  logic        arst_n,

    // Raw strobes from the AFU
    input  logic        c0_valid,
    input  t_mpf_c0_req c0_req,
    output logic        c0_alm_full,
    input  logic        c1_valid,
    input  t_mpf_c1_req c1_req,
    output logic        c1_alm_full,

    // Buffered heads toward the arbiter
    output logic        c0_head_valid,
    output t_mpf_c0_req c0_head,
    output logic        c1_head_valid,
    output t_mpf_c1_req c1_head,

    // A head stays in place until one of these removes it
    input  logic        c0_deq,
    input  logic        c1_deq
);

    localparam int THRESHOLD = `MPF_ALM_FULL_THRESHOLD;

    // Two spare slots beyond the AFU slack keep the almost-full path short
    localparam int N_ENTRIES = THRESHOLD + 2;

    // ====================
    // Channel 0 reads
    // ====================

    t_mpf_c0_req c0_fifo_first;
    logic        c0_fifo_not_empty;
    logic        c0_fifo_enq;
    logic        c0_fifo_deq;

    generate
        if (ENABLE_C0_BYPASS == 0)
        begin : g_c0_nb
            // Every read passes through the FIFO
            assign c0_head       = c0_fifo_first;
            assign c0_head_valid = c0_fifo_not_empty;
            assign c0_fifo_enq   = c0_valid;
            assign c0_fifo_deq   = c0_deq;
        end
        else
        begin : g_c0_b
            // With an empty FIFO the arriving read is offered directly
            assign c0_head       = c0_fifo_not_empty ? c0_fifo_first : c0_req;
            assign c0_head_valid = c0_fifo_not_empty || c0_valid;

            // A bypassed read that was taken this cycle never enters the FIFO
            assign c0_fifo_enq   = c0_valid && (c0_fifo_not_empty || !c0_deq);
            assign c0_fifo_deq   = c0_deq && c0_fifo_not_empty;
        end
    endgenerate

    mpf_fifo_lutram
    #(
        .N_DATA_BITS ($bits(t_mpf_c0_req)),
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    )
    c0_fifo
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .enq_data    (c0_req),
        .enq_en      (c0_fifo_enq),
        .almost_full (c0_alm_full),
        .first       (c0_fifo_first),
        .deq_en      (c0_fifo_deq),
        .not_empty   (c0_fifo_not_empty)
    );

    // ====================
    // Channel 1 writes
    // ====================

    // Same scheme as channel 0 but always through the FIFO
    mpf_fifo_lutram
    #(
        .N_DATA_BITS ($bits(t_mpf_c1_req)),
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    )
    c1_fifo
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .enq_data    (c1_req),
        .enq_en      (c1_valid),
        .almost_full (c1_alm_full),
        .first       (c1_head),
        .deq_en      (c1_deq),
        .not_empty   (c1_head_valid)
    );

endmodule

`default_nettype wire

// ==== verilog/mpf_fifo_lutram.sv ====
// ====================
// MPF LUTRAM FIFO
// Circular buffer with a first-word head and an almost-full threshold
// ====================

`timescale 1ns/1ps
`default_nettype none

module mpf_fifo_lutram
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = 6,
    parameter int THRESHOLD   = 4
)
(
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    output logic                   almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Occupancy at which the free slots drop to THRESHOLD
    localparam int AF_LEVEL = N_ENTRIES - THRESHOLD;

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    count;

    // Pointers wrap at N_ENTRIES, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
        if (p == PTR_BITS'(N_ENTRIES - 1))
            return '0;
        return p + 1'b1;
    endfunction

    // Storage is written at the write pointer on every enqueue
    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (deq_en)
                rd_ptr <= next_ptr(rd_ptr);

            // Simultaneous enq and deq leave the occupancy unchanged
            case ({enq_en, deq_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head is shown combinationally so a consumer can look before it dequeues
    assign first       = mem[rd_ptr];
    assign not_empty   = (count != '0);
    assign almost_full = (count >= CNT_BITS'(AF_LEVEL));

endmodule

`default_nettype wire

// ==== verilog/mpf_pkg.sv ====
// ====================
// MPF request types
// Opcodes, channel identifiers and request structs
// ====================

`include "mpf_cfg.svh"

`default_nettype none

package mpf_pkg;

    // Opcode of a request issued toward the FIU
    typedef enum logic
    {
        REQ_RD = 1'b0,
        REQ_WR = 1'b1
    } t_mpf_req_op;

    // Identifies one of the two AFU request channels
    typedef enum logic
    {
        CHAN_C0 = 1'b0,
        CHAN_C1 = 1'b1
    } t_mpf_chan;

    // Read request header on channel 0
    typedef struct packed
    {
        logic [`MPF_ADDR_BITS-1:0] addr;
    } t_mpf_c0_req;

    // Write request on channel 1, header plus one line of data
    typedef struct packed
    {
        logic [`MPF_ADDR_BITS-1:0] addr;
        logic [`MPF_DATA_BITS-1:0] data;
    } t_mpf_c1_req;

    // Merged request toward the FIU.
    // The data field is zero for reads
    typedef struct packed
    {
        t_mpf_req_op               op;
        logic [`MPF_ADDR_BITS-1:0] addr;
        logic [`MPF_DATA_BITS-1:0] data;
        logic [`MPF_TAG_BITS-1:0]  tag;
    } t_mpf_fiu_req;

endpackage

`default_nettype wire

// ==== verilog/mpf_cfg.svh ====
// ====================
// MPF shim configuration
// Sizes and build options shared by the request path
// ====================

`ifndef MPF_CFG_SVH
`define MPF_CFG_SVH

// Width of the line address carried on both request channels
`define MPF_ADDR_BITS 32

// Width of the line data carried by a write request
`define MPF_DATA_BITS 64

// Width of the running request tag stamped by the output stage
`define MPF_TAG_BITS 8

// The AFU sees almost-full while this many or fewer FIFO slots are free.
// It may still send up to this many requests after almost-full rises
`define MPF_ALM_FULL_THRESHOLD 4

// Nonzero lets an arriving read skip an empty channel 0 FIFO.
// Channel 1 never bypasses because a mux on the line data costs too much
`define MPF_C0_BYPASS 0

`endif
